//--- rtl/lockstep_pkg.sv
package lockstep_pkg;

  // Bus data and address width
  localparam int unsigned DataWidth = 32;
  // One integrity bit per data byte
  localparam int unsigned IntgWidth = DataWidth / 8;

  typedef enum logic [1:0] {
    CoreIdle = 2'b00,
    CoreReq  = 2'b01,
    CoreWait = 2'b10
  } core_state_e;

  //////////////////////
  // Core bus inputs
  //////////////////////

  typedef struct packed {
    logic                 data_gnt;
    logic                 data_rvalid;
    logic [DataWidth-1:0] data_rdata;
    logic                 data_err;
    logic                 fetch_enable;
  } core_in_t;

  //////////////////////
  // Core bus outputs
  //////////////////////

  typedef struct packed {
    logic                 data_req;
    logic                 data_we;
    logic [IntgWidth-1:0] data_be;
    logic [DataWidth-1:0] data_addr;
    logic [DataWidth-1:0] data_wdata;
    logic                 core_busy;
  } core_out_t;

endpackage

//--- rtl/bus_core.sv
module bus_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  in_i,
  output lockstep_pkg::core_out_t out_o,
  output logic                    alert_minor_o,
  output logic                    alert_major_o
);

  // Word counter, the address is this times four
  localparam int unsigned CntWidth = lockstep_pkg::DataWidth - 2;

  lockstep_pkg::core_state_e        state_d, state_q;
  logic [CntWidth-1:0]              cnt_d, cnt_q;
  logic [lockstep_pkg::DataWidth-1:0] acc_d, acc_q;
  logic                             is_write;
  logic                             minor_q, major_q;

  // Every fourth access writes the accumulator back
  assign is_write = (cnt_q[1:0] == 2'b11);

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    acc_d   = acc_q;
    unique case (state_q)
      lockstep_pkg::CoreIdle: begin
        if (in_i.fetch_enable) begin
          state_d = lockstep_pkg::CoreReq;
        end
      end
      lockstep_pkg::CoreReq: begin
        if (in_i.data_gnt) begin
          state_d = lockstep_pkg::CoreWait;
        end
      end
      lockstep_pkg::CoreWait: begin
        if (in_i.data_rvalid) begin
          if (!is_write) begin
            acc_d = acc_q + in_i.data_rdata;
          end
          cnt_d   = cnt_q + CntWidth'(1);
          state_d = in_i.fetch_enable ? lockstep_pkg::CoreReq : lockstep_pkg::CoreIdle;
        end
      end
      default: state_d = lockstep_pkg::CoreIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lockstep_pkg::CoreIdle;
      cnt_q   <= '0;
      acc_q   <= '0;
      minor_q <= 1'b0;
      major_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      acc_q   <= acc_d;
      minor_q <= in_i.data_rvalid & in_i.data_err;
      // Response without an outstanding request
      major_q <= in_i.data_rvalid & (state_q != lockstep_pkg::CoreWait);
    end
  end

  assign out_o.data_req   = (state_q == lockstep_pkg::CoreReq);
  assign out_o.data_we    = is_write;
  assign out_o.data_be    = '1;
  assign out_o.data_addr  = {cnt_q, 2'b00};
  assign out_o.data_wdata = acc_q;
  assign out_o.core_busy  = (state_q != lockstep_pkg::CoreIdle);

  assign alert_minor_o = minor_q;
  assign alert_major_o = major_q;

endmodule

//--- rtl/shadow_reset_gen.sv
module shadow_reset_gen #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  localparam int unsigned CntWidth = (LockstepOffset > 1) ? $clog2(LockstepOffset) : 1;

  logic [CntWidth-1:0] cnt_d, cnt_q;
  logic                rst_set_d, rst_set_q;
  logic                cmp_en_q;

  // Saturate once the delay line is full
  assign rst_set_d = (cnt_q == CntWidth'(LockstepOffset - 1));
  assign cnt_d     = rst_set_d ? cnt_q : (cnt_q + CntWidth'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      rst_set_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      cnt_q     <= cnt_d;
      rst_set_q <= rst_set_d;
      cmp_en_q  <= rst_set_q;
    end
  end

  assign shadow_rst_no = rst_set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

//--- rtl/delay_line.sv
module delay_line #(
  parameter int unsigned Depth = 2,
  parameter int unsigned Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  // Stage 0 is the oldest word
  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      for (int unsigned i = 0; i + 1 < Depth; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[Depth-1] <= data_i;
    end
  end

  assign data_o = stage_q[0];

endmodule

//--- rtl/bus_intg.sv
module bus_intg (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               rvalid_i,
  input  logic [lockstep_pkg::DataWidth-1:0] rdata_i,
  input  logic [lockstep_pkg::IntgWidth-1:0] rdata_intg_i,
  input  logic [lockstep_pkg::DataWidth-1:0] wdata_i,
  output logic [lockstep_pkg::IntgWidth-1:0] wdata_intg_o,
  output logic                               intg_err_o
);

  // Inverted parity over each data byte
  function automatic logic [lockstep_pkg::IntgWidth-1:0] byte_parity(
    input logic [lockstep_pkg::DataWidth-1:0] data
  );
    logic [lockstep_pkg::IntgWidth-1:0] intg;
    for (int i = 0; i < lockstep_pkg::IntgWidth; i++) begin
      intg[i] = ~^data[8*i +: 8];
    end
    return intg;
  endfunction

  logic                               rvalid_q;
  logic [lockstep_pkg::DataWidth-1:0] rdata_q;
  logic [lockstep_pkg::IntgWidth-1:0] rdata_intg_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q      <= rdata_i;
    rdata_intg_q <= rdata_intg_i;
  end

  assign intg_err_o   = rvalid_q & (byte_parity(rdata_q) != rdata_intg_q);
  assign wdata_intg_o = byte_parity(wdata_i);

endmodule

//--- rtl/lockstep_top.sv
module lockstep_top #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  lockstep_pkg::core_in_t             core_in_i,
  input  lockstep_pkg::core_out_t            core_out_i,
  input  logic [lockstep_pkg::IntgWidth-1:0] data_rdata_intg_i,
  output logic [lockstep_pkg::IntgWidth-1:0] data_wdata_intg_o,
  output logic                               alert_minor_o,
  output logic                               alert_major_o
);

  // Extra cycle for the shadow output register
  localparam int unsigned OutputsOffset = LockstepOffset + 1;
  localparam int unsigned InWidth       = $bits(lockstep_pkg::core_in_t);
  localparam int unsigned OutWidth      = $bits(lockstep_pkg::core_out_t);

  ////////////////////
  // Reset generation
  ////////////////////

  logic shadow_rst_n;
  logic cmp_en;

  shadow_reset_gen #(
    .LockstepOffset (LockstepOffset)
  ) u_shadow_reset_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  ////////////////////
  // Delay lines
  ////////////////////

  lockstep_pkg::core_in_t  shadow_in;
  lockstep_pkg::core_out_t core_out_dly;

  delay_line #(
    .Depth (LockstepOffset),
    .Width (InWidth)
  ) u_in_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (core_in_i),
    .data_o (shadow_in)
  );

  delay_line #(
    .Depth (OutputsOffset),
    .Width (OutWidth)
  ) u_out_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (core_out_i),
    .data_o (core_out_dly)
  );

  ////////////////////
  // Bus integrity
  ////////////////////

  logic intg_err;

  bus_intg u_bus_intg (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rvalid_i     (core_in_i.data_rvalid),
    .rdata_i      (core_in_i.data_rdata),
    .rdata_intg_i (data_rdata_intg_i),
    .wdata_i      (core_out_i.data_wdata),
    .wdata_intg_o (data_wdata_intg_o),
    .intg_err_o   (intg_err)
  );

  ////////////////////
  // Shadow core
  ////////////////////

  lockstep_pkg::core_out_t shadow_out_d, shadow_out_q;
  logic                    shadow_alert_minor, shadow_alert_major;

  bus_core u_shadow_core (
    .clk_i         (clk_i),
    .rst_ni        (shadow_rst_n),
    .in_i          (shadow_in),
    .out_o         (shadow_out_d),
    .alert_minor_o (shadow_alert_minor),
    .alert_major_o (shadow_alert_major)
  );

  always_ff @(posedge clk_i) begin
    shadow_out_q <= shadow_out_d;
  end

  ////////////////////
  // Compare
  ////////////////////

  logic outputs_mismatch;

  assign outputs_mismatch = cmp_en & (shadow_out_q != core_out_dly);
  assign alert_major_o    = outputs_mismatch | shadow_alert_major | intg_err;
  assign alert_minor_o    = shadow_alert_minor;

endmodule

//--- tests/tb_lockstep.sv
module tb_lockstep;

  localparam int unsigned LockstepOffset = 2;
  localparam int unsigned AccessCount    = 200;
  localparam int unsigned ReqTimeout     = 64;
  localparam logic [31:0] LfsrSeed       = 32'h81ae_dd11;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LfsrTaps       = 32'h8020_0003;

  logic clk = 1'b0;
  logic rst_n;
  logic quiet_chk;
  logic [31:0] lfsr_q = LfsrSeed;
  logic [lockstep_pkg::DataWidth-1:0] addr_xor;
  logic [lockstep_pkg::IntgWidth-1:0] rdata_intg;
  logic [lockstep_pkg::IntgWidth-1:0] wdata_intg;
  logic alert_minor, alert_major;
  lockstep_pkg::core_in_t  main_in;
  lockstep_pkg::core_out_t main_out, dut_out;

  always #20 clk = ~clk;

  bus_core u_main_core (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .in_i          (main_in),
    .out_o         (main_out),
    .alert_minor_o (),
    .alert_major_o ()
  );

  // Address corruption on the path into the checker
  always_comb begin
    dut_out           = main_out;
    dut_out.data_addr = main_out.data_addr ^ addr_xor;
  end

  lockstep_top #(
    .LockstepOffset (LockstepOffset)
  ) i_lockstep_top (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .core_in_i         (main_in),
    .core_out_i        (dut_out),
    .data_rdata_intg_i (rdata_intg),
    .data_wdata_intg_o (wdata_intg),
    .alert_minor_o     (alert_minor),
    .alert_major_o     (alert_major)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LfsrTaps;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] val);
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // One bit per byte that is set for an even number of ones
  function automatic logic [lockstep_pkg::IntgWidth-1:0] expected_intg(
    input logic [lockstep_pkg::DataWidth-1:0] data
  );
    logic [lockstep_pkg::IntgWidth-1:0] intg;
    int ones;
    for (int b = 0; b < lockstep_pkg::IntgWidth; b++) begin
      ones = 0;
      for (int k = 0; k < 8; k++) begin
        ones += data[8*b+k];
      end
      intg[b] = (ones % 2 == 0);
    end
    return intg;
  endfunction

  always @(negedge clk) begin
    assert (wdata_intg == expected_intg(main_out.data_wdata)) else
      report_failure($sformatf("error data_wdata_intg_o: got %h expected %h",
                               wdata_intg, expected_intg(main_out.data_wdata)));
    if (quiet_chk) begin
      assert (!alert_major) else
        report_failure($sformatf("error alert_major_o: got %h expected %h", alert_major, 1'b0));
      assert (!alert_minor) else
        report_failure($sformatf("error alert_minor_o: got %h expected %h", alert_minor, 1'b0));
    end
  end

  task automatic wait_for_request();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > ReqTimeout) begin
        report_failure("timeout: main core never raised data_req");
      end
    end while (!main_out.data_req);
  endtask

  // Grants and answers one request and returns right after the response edge
  task automatic do_access(input logic flip_intg, input logic with_err);
    logic [31:0] gnt_dly, rsp_dly, rdata;
    wait_for_request();
    take_bits(2, gnt_dly);
    @(posedge clk);
    repeat (gnt_dly) @(posedge clk);
    main_in.data_gnt <= 1'b1;
    @(posedge clk);
    main_in.data_gnt <= 1'b0;
    take_bits(2, rsp_dly);
    take_bits(32, rdata);
    repeat (rsp_dly) @(posedge clk);
    main_in.data_rvalid <= 1'b1;
    main_in.data_rdata  <= rdata;
    main_in.data_err    <= with_err;
    rdata_intg          <= expected_intg(rdata) ^ {3'b000, flip_intg};
    @(posedge clk);
    main_in.data_rvalid <= 1'b0;
    main_in.data_err    <= 1'b0;
    rdata_intg          <= expected_intg(rdata);
  endtask

  initial begin : stimulus
    int waited;
    rst_n      = 1'b0;
    main_in    = '0;
    addr_xor   = '0;
    rdata_intg = expected_intg('0);
    quiet_chk  = 1'b1;
    repeat (10) @(posedge clk);
    rst_n                <= 1'b1;
    main_in.fetch_enable <= 1'b1;

    // Matching traffic
    for (int i = 0; i < AccessCount; i++) begin
      do_access(1'b0, 1'b0);
    end

    ////////////////////
    // Read integrity
    ////////////////////
    do_access(1'b1, 1'b0);
    quiet_chk = 1'b0;
    @(negedge clk);
    assert (alert_major) else
      report_failure($sformatf("error alert_major_o: got %h expected %h", alert_major, 1'b1));
    @(negedge clk);
    assert (!alert_major) else
      report_failure($sformatf("error alert_major_o: got %h expected %h", alert_major, 1'b0));
    @(posedge clk);
    quiet_chk = 1'b1;
    // Same flip without a response raises nothing
    rdata_intg <= expected_intg(main_in.data_rdata) ^ 4'b0001;
    @(posedge clk);
    rdata_intg <= expected_intg(main_in.data_rdata);
    repeat (LockstepOffset + 3) @(posedge clk);

    ////////////////////
    // Output mismatch
    ////////////////////
    quiet_chk = 1'b0;
    addr_xor <= 32'h0000_0100;
    for (int k = 0; k < LockstepOffset + 4; k++) begin
      @(negedge clk);
      assert (alert_major == (k == LockstepOffset + 1)) else
        report_failure($sformatf("error alert_major_o: got %h expected %h",
                                 alert_major, (k == LockstepOffset + 1)));
      @(posedge clk);
      if (k == 0) begin
        addr_xor <= '0;
      end
    end
    quiet_chk = 1'b1;

    // Bus error response
    do_access(1'b0, 1'b1);
    quiet_chk = 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      assert (!alert_major) else
        report_failure($sformatf("error alert_major_o: got %h expected %h", alert_major, 1'b0));
      if (waited > LockstepOffset + 2) begin
        report_failure("timeout: alert_minor_o never rose after a bus error");
      end
    end while (!alert_minor);
    @(negedge clk);
    assert (!alert_minor) else
      report_failure($sformatf("error alert_minor_o: got %h expected %h", alert_minor, 1'b0));
    @(posedge clk);
    quiet_chk = 1'b1;

    ////////////////////
    // Response while idle
    ////////////////////
    main_in.fetch_enable <= 1'b0;
    do_access(1'b0, 1'b0);
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > ReqTimeout) begin
        report_failure("timeout: main core did not return to idle");
      end
    end while (main_out.core_busy);
    repeat (LockstepOffset + 2) @(posedge clk);
    quiet_chk = 1'b0;
    main_in.data_rvalid <= 1'b1;
    @(posedge clk);
    main_in.data_rvalid <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > LockstepOffset + 2) begin
        report_failure("timeout: alert_major_o stayed low after a response while idle");
      end
    end while (!alert_major);

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- build.f
rtl/lockstep_pkg.sv
rtl/bus_core.sv
rtl/shadow_reset_gen.sv
rtl/delay_line.sv
rtl/bus_intg.sv
rtl/lockstep_top.sv
tests/tb_lockstep.sv

//--- Bender.yml
package:
  name: lockstep

sources:
  - rtl/lockstep_pkg.sv
  - rtl/bus_core.sv
  - rtl/shadow_reset_gen.sv
  - rtl/delay_line.sv
  - rtl/bus_intg.sv
  - rtl/lockstep_top.sv
  - target: test
    files:
      - tests/tb_lockstep.sv
